//--- test/frame_wr_vectors.mem
// header: test ready_mask stall_mode bursts frame_end_ch frame_end_after frame_end_after
// then the expected awaddr of each burst in order, ff means no frame_end
1 7 0 f 0 ff ff
0000000 0040000 0080000
0000040 0040040 0080040
0000080 0040080 0080080
00000c0 00400c0 00800c0
0000100 0040100 0080100
2 7 1 9 0 ff ff
0000000 0040000 0080000
0000040 0040040 0080040
0000080 0040080 0080080
3 7 0 9 1 1 4
0000000 0040000 0080000
0000040 0050000 0080040
0000080 0040000 0080080
4 5 1 6 0 ff ff
0000000 0080000 0000040
0080040 0000080 0080080

//--- project.f
+incdir+hw
hw/axi_wr_pkg.sv
hw/frame_wr_pkg.sv
hw/axi_slice.sv
hw/burst_sequencer.sv
hw/burst_addr_gen.sv
hw/beat_fetch.sv
hw/frame_wr_top.sv
test/frame_wr_assert.sv
test/frame_wr_tb.sv

//--- test/frame_wr_tb.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module frame_wr_tb;

    localparam int NCH       = `FW_NUM_CH;
    localparam int VEC_DEPTH = 128;
    localparam int BUF_DEPTH = 1 << `FW_BUF_ADDR_W;

    logic                    clk;
    logic                    rst;
    logic [NCH-1:0]          frame_end;
    frame_wr_pkg::buf_rsp_t  buf_rsp [NCH];
    frame_wr_pkg::buf_req_t  buf_req [NCH];
    axi_wr_pkg::aw_payload_t aw;
    logic                    awvalid;
    logic                    awready;
    axi_wr_pkg::w_payload_t  w;
    logic                    wvalid;
    logic                    wready;
    logic                    bvalid;
    logic                    bready;

    logic [31:0]    vec [0:VEC_DEPTH-1];
    logic [31:0]    exp_addr [$];
    logic [NCH-1:0] ready_mask;
    logic [NCH-1:0] t_mask;                 // ready mask of the running test
    int             t_stall, t_bursts, fe_ch, fe_at0, fe_at1;
    int             aw_cnt, last_cnt, b_cnt, beat_idx;
    int             pops [NCH];
    int             beats [NCH];
    int             exp_ptr [NCH];
    bit             aw_hs, w_hs, b_hs;      // handshakes at the coming edge
    int             errors, cycles, limit;

    frame_wr_top uut (
        .clk       (clk),
        .rst       (rst),
        .frame_end (frame_end),
        .buf_rsp   (buf_rsp),
        .buf_req   (buf_req),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // channel in top byte, buffer address in low byte
    function automatic logic [63:0] buf_word(input int ch, input int addr);
        return {8'(ch), 48'h5a5a_c3c3_0ff0, 8'(addr)};
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_fault(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    always_comb begin
        for (int c = 0; c < NCH; c++) begin
            buf_rsp[c].ready = ready_mask[c];
            buf_rsp[c].data  = buf_word(c, buf_req[c].rd_addr);
        end
    end

    always @(negedge clk) begin : monitor
        int ch;
        aw_hs = rst && awvalid && awready;
        w_hs  = rst && wvalid && wready;
        b_hs  = rst && bvalid && bready;
        if (b_hs)
            b_cnt++;
        if (aw_hs) begin
            if (aw_cnt < t_bursts)
                check_eq("awaddr", aw.addr, exp_addr[aw_cnt]);
            else
                report_fault("address burst beyond the expected count");
            aw_cnt++;
        end
        if (w_hs && last_cnt >= t_bursts) begin
            report_fault("data beat beyond the expected bursts");
        end else if (w_hs) begin
            ch = exp_addr[last_cnt] / `FW_CH_STRIDE;
            check_eq("wdata", w.data, buf_word(ch, exp_ptr[ch]));
            check_eq("wlast", w.last, beat_idx == `FW_BURST_LEN - 1);
            exp_ptr[ch] = (exp_ptr[ch] + 1) % BUF_DEPTH;
            beats[ch]++;
            beat_idx++;
            if (beat_idx == `FW_BURST_LEN) begin
                beat_idx = 0;
                last_cnt++;
            end
        end
        for (int c = 0; c < NCH; c++) begin
            if (rst && buf_req[c].rd_en) begin
                pops[c]++;
                if (!t_mask[c])
                    report_fault($sformatf("pop on channel %0d whose buffer is not ready", c));
            end
            // at most one popped beat waits in the data slice
            if (pops[c] < beats[c] || pops[c] > beats[c] + 1)
                report_fault($sformatf("pop on channel %0d without an accepted beat", c));
        end
    end

    // slave model with random stalls in stall mode 1
    initial begin
        void'($urandom(32'h9404_a474));
        forever begin
            @(posedge clk);
            frame_end <= '0;
            awready   <= (t_stall == 0) || ($urandom % 2 == 1);
            wready    <= (t_stall == 0) || ($urandom % 2 == 1);
            if (!rst || b_hs) begin
                bvalid <= 1'b0;
            end else if (!bvalid && last_cnt > b_cnt && aw_cnt > b_cnt) begin
                bvalid <= (t_stall == 0) || ($urandom % 2 == 1);
            end
            if (b_hs && (b_cnt - 1 == fe_at0 || b_cnt - 1 == fe_at1))
                frame_end <= NCH'(1) << fe_ch;
            if (b_hs && b_cnt == t_bursts)
                ready_mask <= '0;               // hold off further bursts
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, bursts did not complete", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic start_test(input int p);
        @(posedge clk);
        rst        <= 1'b0;
        ready_mask <= '0;
        @(negedge clk);
        t_mask   = vec[p+1][NCH-1:0];
        t_stall  = vec[p+2];
        t_bursts = vec[p+3];
        fe_ch    = vec[p+4];
        fe_at0   = vec[p+5];
        fe_at1   = vec[p+6];
        exp_addr.delete();
        for (int i = 0; i < t_bursts; i++)
            exp_addr.push_back(vec[p+7+i]);
        aw_cnt   = 0;
        last_cnt = 0;
        b_cnt    = 0;
        beat_idx = 0;
        for (int c = 0; c < NCH; c++) begin
            pops[c]    = 0;
            beats[c]   = 0;
            exp_ptr[c] = 0;
        end
        repeat (3) @(posedge clk);
        rst        <= 1'b1;
        ready_mask <= t_mask;
        @(negedge clk);
        check_eq("awvalid", awvalid, 0);
        check_eq("wvalid", wvalid, 0);
        check_eq("bready", bready, 0);
        for (int c = 0; c < NCH; c++)
            check_eq($sformatf("rd_en[%0d]", c), buf_req[c].rd_en, 0);
    endtask

    initial begin
        int p;
        int total;
        int ntests;
        int t_err;
        rst        = 1'b0;
        frame_end  = '0;
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        ready_mask = '0;
        t_mask     = '0;
        t_stall    = 0;
        t_bursts   = 0;
        errors     = 0;
        $readmemh("test/frame_wr_vectors.mem", vec);
        p     = 0;
        total = 0;
        while (p < VEC_DEPTH && !$isunknown(vec[p])) begin
            total += vec[p+3];
            p     += 7 + vec[p+3];
        end
        limit  = total * (`FW_BURST_LEN + 4) * 4 + 100;
        p      = 0;
        ntests = 0;
        while (p < VEC_DEPTH && !$isunknown(vec[p])) begin
            t_err = errors;
            start_test(p);
            while (b_cnt < t_bursts)
                @(posedge clk);
            repeat (4) @(negedge clk);
            check_eq("address bursts", aw_cnt, t_bursts);
            for (int c = 0; c < NCH; c++)
                check_eq($sformatf("pops[%0d]", c), pops[c], beats[c]);
            $display("test %0d: %0d bursts, %0d errors", vec[p], t_bursts, errors - t_err);
            ntests++;
            p += 7 + t_bursts;
        end
        errors += uut.u_assert.fail_cnt;    // handshake assertion failures
        $display("%0d tests run, %0d errors", ntests, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- test/frame_wr_assert.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module frame_wr_assert (
    input logic                    clk,
    input logic                    rst,
    input axi_wr_pkg::aw_payload_t aw,
    input logic                    awvalid,
    input logic                    awready,
    input axi_wr_pkg::w_payload_t  w,
    input logic                    wvalid,
    input logic                    wready,
    input logic                    w_push,
    input logic                    bvalid,
    input logic                    bready
);

    logic [$clog2(`FW_BURST_LEN):0] pushed;     // beats pushed for the open burst
    int                             fail_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pushed <= '0;
        end else if (bvalid && bready) begin
            pushed <= '0;
        end else if (w_push) begin
            pushed <= pushed + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else begin
            $error("aw channel changed before awready");
            fail_cnt++;
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        wvalid && !wready |=> wvalid && $stable(w))
        else begin
            $error("w channel changed before wready");
            fail_cnt++;
        end

    b_after_last: assert property (@(posedge clk) disable iff (!rst)
        bready |-> (pushed == `FW_BURST_LEN))
        else begin
            $error("bready raised before the last beat was sent");
            fail_cnt++;
        end

endmodule

bind frame_wr_top frame_wr_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .w_push  (w_push),
    .bvalid  (bvalid),
    .bready  (bready)
);

//--- hw/frame_wr_top.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module frame_wr_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FW_NUM_CH-1:0]   frame_end,
    input  frame_wr_pkg::buf_rsp_t  buf_rsp [`FW_NUM_CH],
    output frame_wr_pkg::buf_req_t  buf_req [`FW_NUM_CH],
    output axi_wr_pkg::aw_payload_t aw,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_wr_pkg::w_payload_t  w,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);

    logic [`FW_NUM_CH-1:0]   ch_ready;
    logic                    aw_push;
    logic                    aw_in_ready;
    axi_wr_pkg::aw_payload_t aw_next;
    logic                    w_push;
    logic                    w_in_ready;
    axi_wr_pkg::w_payload_t  w_next;
    logic                    burst_done;
    logic                    data_active;
    frame_wr_pkg::ch_idx_t   cur_ch;

    for (genvar c = 0; c < `FW_NUM_CH; c++) begin : g_rdy
        assign ch_ready[c] = buf_rsp[c].ready;
    end

    burst_sequencer u_seq (
        .clk         (clk),
        .rst         (rst),
        .ch_ready    (ch_ready),
        .aw_ready    (aw_in_ready),
        .aw_push     (aw_push),
        .burst_done  (burst_done),
        .data_active (data_active),
        .bvalid      (bvalid),
        .bready      (bready),
        .cur_ch      (cur_ch)
    );

    burst_addr_gen u_addr (
        .clk       (clk),
        .rst       (rst),
        .frame_end (frame_end),
        .cur_ch    (cur_ch),
        .aw_push   (aw_push),
        .aw        (aw_next)
    );

    beat_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .cur_ch      (cur_ch),
        .data_active (data_active),
        .buf_rsp     (buf_rsp),
        .buf_req     (buf_req),
        .w_push      (w_push),
        .w           (w_next),
        .w_ready     (w_in_ready),
        .burst_done  (burst_done)
    );

    // address channel register
    axi_slice #(.payload_t(axi_wr_pkg::aw_payload_t)) aw_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (aw_push),
        .in_ready  (aw_in_ready),
        .in_data   (aw_next),
        .out_valid (awvalid),
        .out_ready (awready),
        .out_data  (aw)
    );

    // data channel register
    axi_slice #(.payload_t(axi_wr_pkg::w_payload_t)) w_slice (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (w_push),
        .in_ready  (w_in_ready),
        .in_data   (w_next),
        .out_valid (wvalid),
        .out_ready (wready),
        .out_data  (w)
    );

endmodule

//--- hw/beat_fetch.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module beat_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  frame_wr_pkg::ch_idx_t  cur_ch,
    input  logic                   data_active,
    input  frame_wr_pkg::buf_rsp_t buf_rsp [`FW_NUM_CH],
    output frame_wr_pkg::buf_req_t buf_req [`FW_NUM_CH],
    output logic                   w_push,
    output axi_wr_pkg::w_payload_t w,
    input  logic                   w_ready,
    output logic                   burst_done
);

    localparam int                BEAT_W    = $clog2(`FW_BURST_LEN);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`FW_BURST_LEN - 1);

    logic [`FW_BUF_ADDR_W-1:0] rd_ptr [`FW_NUM_CH];
    logic [BEAT_W-1:0]         beat_cnt;

    // one beat per cycle while the data slice has room
    assign w_push     = data_active && w_ready;
    assign w.data     = buf_rsp[cur_ch].data;
    assign w.last     = (beat_cnt == LAST_BEAT);
    assign burst_done = w_push && w.last;

    for (genvar c = 0; c < `FW_NUM_CH; c++) begin : g_req
        assign buf_req[c].rd_en   = w_push && (cur_ch == c);    // pop only accepted beats
        assign buf_req[c].rd_addr = rd_ptr[c];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beat_cnt <= '0;
            for (int c = 0; c < `FW_NUM_CH; c++) begin
                rd_ptr[c] <= '0;
            end
        end else if (w_push) begin
            beat_cnt       <= w.last ? '0 : beat_cnt + 1'b1;
            rd_ptr[cur_ch] <= rd_ptr[cur_ch] + 1'b1;    // wraps at buffer depth
        end
    end

endmodule

//--- hw/burst_addr_gen.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module burst_addr_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`FW_NUM_CH-1:0]   frame_end,
    input  frame_wr_pkg::ch_idx_t   cur_ch,
    input  logic                    aw_push,
    output axi_wr_pkg::aw_payload_t aw
);

    localparam logic [`FW_ADDR_W-1:0] BURST_BYTES =
        `FW_ADDR_W'(`FW_BURST_LEN * `FW_BEAT_BYTES);
    localparam logic [`FW_ADDR_W-1:0] BANK_SPAN = `FW_ADDR_W'(`FW_BANK_SPAN);

    logic [`FW_ADDR_W-1:0] offset [`FW_NUM_CH];
    logic [`FW_NUM_CH-1:0] bank;
    logic [`FW_NUM_CH-1:0] pend;            // frame_end seen, flip at next burst
    logic [`FW_NUM_CH-1:0] clr_mask;
    logic                  flip;
    logic                  use_bank;
    logic [`FW_ADDR_W-1:0] use_offset;
    logic [`FW_ADDR_W-1:0] ch_base;

    assign flip       = pend[cur_ch];
    assign use_bank   = bank[cur_ch] ^ flip;
    assign use_offset = flip ? '0 : offset[cur_ch];
    assign ch_base    = `FW_ADDR_W'(cur_ch * `FW_CH_STRIDE);

    assign aw.addr = ch_base + (use_bank ? BANK_SPAN : '0) + use_offset;

    assign clr_mask = aw_push ? (`FW_NUM_CH'(1) << cur_ch) : '0;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank <= '0;
            pend <= '0;
            for (int c = 0; c < `FW_NUM_CH; c++) begin
                offset[c] <= '0;
            end
        end else begin
            // a pulse during the push still counts for the next burst
            pend <= (pend & ~clr_mask) | frame_end;
            if (aw_push) begin
                offset[cur_ch] <= use_offset + BURST_BYTES;
                bank[cur_ch]   <= use_bank;
            end
        end
    end

endmodule

//--- hw/burst_sequencer.sv
`timescale 1ns/1ps
`include "frame_wr_consts.svh"

module burst_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`FW_NUM_CH-1:0] ch_ready,
    input  logic                  aw_ready,
    output logic                  aw_push,
    input  logic                  burst_done,
    output logic                  data_active,
    input  logic                  bvalid,
    output logic                  bready,
    output frame_wr_pkg::ch_idx_t cur_ch
);

    localparam frame_wr_pkg::ch_idx_t LAST_CH = frame_wr_pkg::ch_idx_t'(`FW_NUM_CH - 1);

    frame_wr_pkg::seq_state_t state;
    frame_wr_pkg::ch_idx_t    next_ch;

    // cyclic channel order
    assign next_ch = (cur_ch == LAST_CH) ? '0 : cur_ch + 1'b1;

    assign aw_push     = (state == frame_wr_pkg::ADDR) && aw_ready;
    assign data_active = (state == frame_wr_pkg::DATA);
    assign bready      = (state == frame_wr_pkg::RESP);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= frame_wr_pkg::SEL;
            cur_ch <= '0;
        end else begin
            case (state)
                frame_wr_pkg::SEL: begin
                    if (ch_ready[cur_ch]) begin
                        state <= frame_wr_pkg::ADDR;
                    end else begin
                        cur_ch <= next_ch;          // pass over idle channel
                    end
                end
                frame_wr_pkg::ADDR: begin
                    if (aw_push) begin
                        state <= frame_wr_pkg::DATA;
                    end
                end
                frame_wr_pkg::DATA: begin
                    if (burst_done) begin
                        state <= frame_wr_pkg::RESP;
                    end
                end
                frame_wr_pkg::RESP: begin
                    // burst complete on b handshake
                    if (bvalid) begin
                        state  <= frame_wr_pkg::SEL;
                        cur_ch <= next_ch;
                    end
                end
                default: begin
                    state <= frame_wr_pkg::SEL;
                end
            endcase
        end
    end

endmodule

//--- hw/axi_slice.sv
`timescale 1ns/1ps

module axi_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // empty, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only loads on an accepted item
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- hw/frame_wr_pkg.sv
`include "frame_wr_consts.svh"

package frame_wr_pkg;

    // writer to line buffer
    typedef struct packed {
        logic                      rd_en;      // pops word at rd_addr
        logic [`FW_BUF_ADDR_W-1:0] rd_addr;
    } buf_req_t;

    // line buffer to writer
    typedef struct packed {
        logic                  ready;          // at least one burst held
        logic [`FW_DATA_W-1:0] data;           // word at rd_addr, comb
    } buf_rsp_t;

    typedef logic [1:0] ch_idx_t;

    typedef enum logic [1:0] {
        SEL,
        ADDR,
        DATA,
        RESP
    } seq_state_t;

endpackage

//--- hw/axi_wr_pkg.sv
`include "frame_wr_consts.svh"

package axi_wr_pkg;

    // write address only, burst shape is fixed
    typedef struct packed {
        logic [`FW_ADDR_W-1:0] addr;
    } aw_payload_t;

    // one write beat
    typedef struct packed {
        logic [`FW_DATA_W-1:0] data;
        logic                  last;    // final beat of the burst
    } w_payload_t;

endpackage

//--- hw/frame_wr_consts.svh
`ifndef FRAME_WR_CONSTS_SVH
`define FRAME_WR_CONSTS_SVH

// video channels served in turn
`define FW_NUM_CH       3

// AXI data beat
`define FW_DATA_W       64
`define FW_BEAT_BYTES   8
`define FW_BURST_LEN    8           // beats per INCR burst

// DDR byte address
`define FW_ADDR_W       28

// line buffer read pointer
`define FW_BUF_ADDR_W   5

// memory map of the frame banks
`define FW_BANK_SPAN    'h1_0000    // bank 0 to bank 1
`define FW_CH_STRIDE    'h4_0000    // start of next channel region

`endif
